/* common/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // one instruction word with two field layouts
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
    } r_view;
    struct packed {
      logic [6:0] imm_hi;  // also branch offset high bits
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s_view;
  } inst_u;

  // major opcodes of the supported subset
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_OR  = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_EQ  = 4'd5;  // beq compare
  localparam logic [ALU_OP_W-1:0] ALU_NE  = 4'd6;  // bne compare

  // operand source for the execute stage
  localparam logic [1:0] FWD_NONE = 2'd0;
  localparam logic [1:0] FWD_MEM  = 2'd1;
  localparam logic [1:0] FWD_WB   = 2'd2;

endpackage

/* core/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [32];  // entry 0 is never written

  logic wr_live;

  assign wr_live = rd_we && (rd_idx != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // writeback value seen by decode in the same cycle
  assign rs1_data = (wr_live && rd_idx == rs1_idx) ? rd_data : regs[rs1_idx];
  assign rs2_data = (wr_live && rd_idx == rs2_idx) ? rd_data : regs[rs2_idx];

endmodule

/* core/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
  input  rv_pkg::inst_u                inst,
  output logic [rv_pkg::ALU_OP_W-1:0]  alu_op,
  output rv_pkg::word_t                imm,
  output logic                         alu_src_imm,
  output logic                         reg_write,
  output logic                         mem_read,
  output logic                         mem_write,
  output logic                         is_branch,
  output logic                         is_jal,
  output logic                         is_ecall
);

  logic [6:0] f7;
  logic [2:0] f3;

  assign f7 = inst.r_view.funct7;
  assign f3 = inst.r_view.funct3;

  always_comb begin
    alu_op      = rv_pkg::ALU_ADD;
    imm         = '0;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_ecall    = 1'b0;
    case (inst.r_view.opcode)
      rv_pkg::OP_R: begin
        reg_write = 1'b1;
        case (f3)
          3'b000:  alu_op = f7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b010:  alu_op = rv_pkg::ALU_SLT;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          3'b111:  alu_op = rv_pkg::ALU_AND;
          default: reg_write = 1'b0;  // unsupported funct3, acts as nop
        endcase
      end
      rv_pkg::OP_IMM: begin
        reg_write   = (f3 == 3'b000);  // addi only
        alu_src_imm = 1'b1;
        imm         = {{20{f7[6]}}, f7, inst.r_view.rs2};
      end
      rv_pkg::OP_LOAD: begin
        reg_write   = 1'b1;
        mem_read    = 1'b1;
        alu_src_imm = 1'b1;
        imm         = {{20{f7[6]}}, f7, inst.r_view.rs2};
      end
      rv_pkg::OP_STORE: begin
        mem_write   = 1'b1;
        alu_src_imm = 1'b1;
        imm         = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
      end
      rv_pkg::OP_BRANCH: begin
        is_branch = (f3 == 3'b000) || (f3 == 3'b001);
        alu_op    = f3[0] ? rv_pkg::ALU_NE : rv_pkg::ALU_EQ;
        // b-type offset rebuilt from the store layout
        imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_lo[0],
               inst.s_view.imm_hi[5:0], inst.s_view.imm_lo[4:1], 1'b0};
      end
      rv_pkg::OP_JAL: begin
        reg_write = 1'b1;
        is_jal    = 1'b1;
        imm = {{12{f7[6]}}, inst.r_view.rs1, f3, inst.r_view.rs2[0],
               f7[5:0], inst.r_view.rs2[4:1], 1'b0};
      end
      rv_pkg::OP_SYSTEM: is_ecall = 1'b1;
      default: ;
    endcase
  end

endmodule

/* core/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  rv_pkg::reg_idx_t id_rs1,
  input  rv_pkg::reg_idx_t id_rs2,
  input  rv_pkg::reg_idx_t ex_rs1,
  input  rv_pkg::reg_idx_t ex_rs2,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             ex_mem_read,
  input  rv_pkg::reg_idx_t mem_rd,
  input  logic             mem_reg_write,
  input  rv_pkg::reg_idx_t wb_rd,
  input  logic             wb_reg_write,
  output logic             stall,
  output logic [1:0]       fwd_a,
  output logic [1:0]       fwd_b
);

  logic mem_hit_a, mem_hit_b, wb_hit_a, wb_hit_b;

  // load in execute feeding the instruction in decode
  assign stall = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

  assign mem_hit_a = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs1);
  assign mem_hit_b = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs2);
  assign wb_hit_a  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs1);
  assign wb_hit_b  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs2);

  // younger result wins
  always_comb begin
    fwd_a = rv_pkg::FWD_NONE;
    fwd_b = rv_pkg::FWD_NONE;
    if (mem_hit_a) fwd_a = rv_pkg::FWD_MEM;
    else if (wb_hit_a) fwd_a = rv_pkg::FWD_WB;
    if (mem_hit_b) fwd_b = rv_pkg::FWD_MEM;
    else if (wb_hit_b) fwd_b = rv_pkg::FWD_WB;
  end

endmodule

/* core/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::ALU_OP_W-1:0] alu_op,
  input  rv_pkg::word_t               in_a,
  input  rv_pkg::word_t               in_b,
  output rv_pkg::word_t               result,
  output logic                        branch_taken
);

  always_comb begin
    result       = '0;
    branch_taken = 1'b0;
    case (alu_op)
      rv_pkg::ALU_ADD: result = in_a + in_b;
      rv_pkg::ALU_SUB: result = in_a - in_b;
      rv_pkg::ALU_AND: result = in_a & in_b;
      rv_pkg::ALU_OR:  result = in_a | in_b;
      rv_pkg::ALU_SLT: result = {31'b0, $signed(in_a) < $signed(in_b)};
      rv_pkg::ALU_EQ:  branch_taken = (in_a == in_b);
      rv_pkg::ALU_NE:  branch_taken = (in_a != in_b);
      default: ;  // result stays zero
    endcase
  end

endmodule

/* core/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic             clk,
  input  logic             reset,
  output rv_pkg::word_t    imem_addr,
  input  rv_pkg::word_t    imem_data,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output logic             dmem_we,
  input  rv_pkg::word_t    dmem_rdata,
  output logic             retire_valid,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::word_t    retire_data,
  output logic             is_halted
);

  // byte address widths covering each memory
  localparam int IMEM_AW = $clog2(IMEM_WORDS) + 2;
  localparam int DMEM_AW = $clog2(DMEM_WORDS) + 2;

  rv_pkg::word_t pc;
  logic          fetch_stop;  // set once ecall has left decode

  logic          if_id_valid;
  rv_pkg::inst_u if_id_inst;
  rv_pkg::word_t if_id_pc;

  logic [rv_pkg::ALU_OP_W-1:0] dec_alu_op;
  rv_pkg::word_t dec_imm, rs1_data, rs2_data;
  logic dec_alu_src_imm, dec_reg_write, dec_mem_read, dec_mem_write;
  logic dec_is_branch, dec_is_jal, dec_is_ecall;

  logic                        id_ex_valid;
  logic [rv_pkg::ALU_OP_W-1:0] id_ex_alu_op;
  logic id_ex_alu_src_imm, id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
  logic id_ex_is_branch, id_ex_is_jal, id_ex_is_ecall;
  rv_pkg::word_t    id_ex_pc, id_ex_imm, id_ex_rs1_data, id_ex_rs2_data;
  rv_pkg::reg_idx_t id_ex_rs1, id_ex_rs2, id_ex_rd;

  logic ex_mem_valid, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_is_ecall;
  rv_pkg::word_t    ex_mem_result, ex_mem_store_data;
  rv_pkg::reg_idx_t ex_mem_rd;

  logic mem_wb_valid, mem_wb_reg_write, mem_wb_mem_read, mem_wb_is_ecall;
  rv_pkg::word_t    mem_wb_result, mem_wb_rdata;
  rv_pkg::reg_idx_t mem_wb_rd;

  logic          stall, redirect, ecall_in_id, fetch_freeze, branch_taken;
  logic [1:0]    fwd_a, fwd_b;
  rv_pkg::word_t op_a, op_b_reg, alu_in_b, alu_result, ex_result, wb_data, target;

  function automatic rv_pkg::word_t fwd_pick(input logic [1:0] sel, input rv_pkg::word_t reg_val,
                                              input rv_pkg::word_t mem_val,
                                              input rv_pkg::word_t wb_val);
    case (sel)
      rv_pkg::FWD_MEM: return mem_val;
      rv_pkg::FWD_WB:  return wb_val;
      default:         return reg_val;
    endcase
  endfunction

  assign imem_addr    = rv_pkg::word_t'(pc[IMEM_AW-1:0]);
  assign ecall_in_id  = if_id_valid && dec_is_ecall;
  assign fetch_freeze = fetch_stop || ecall_in_id;
  assign redirect     = id_ex_valid && (id_ex_is_jal || (id_ex_is_branch && branch_taken));
  assign target       = id_ex_pc + id_ex_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      fetch_stop  <= 1'b0;
      if_id_valid <= 1'b0;
    end else if (redirect) begin
      pc          <= target;
      if_id_valid <= 1'b0;  // squash wrong-path fetch
    end else if (!stall) begin
      if (fetch_freeze) begin
        if_id_valid <= 1'b0;
        fetch_stop  <= 1'b1;
      end else begin
        pc          <= pc + 32'd4;
        if_id_valid <= 1'b1;
        if_id_inst  <= imem_data;
        if_id_pc    <= pc;
      end
    end
  end

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_idx  (if_id_inst.r_view.rs1),
    .rs2_idx  (if_id_inst.r_view.rs2),
    .rd_idx   (mem_wb_rd),
    .rd_we    (mem_wb_valid && mem_wb_reg_write),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  decode_unit u_decode (
    .inst        (if_id_inst),
    .alu_op      (dec_alu_op),
    .imm         (dec_imm),
    .alu_src_imm (dec_alu_src_imm),
    .reg_write   (dec_reg_write),
    .mem_read    (dec_mem_read),
    .mem_write   (dec_mem_write),
    .is_branch   (dec_is_branch),
    .is_jal      (dec_is_jal),
    .is_ecall    (dec_is_ecall)
  );

  logic hz_stall;

  hazard_unit u_hazard (
    .id_rs1        (if_id_inst.r_view.rs1),
    .id_rs2        (if_id_inst.r_view.rs2),
    .ex_rs1        (id_ex_rs1),
    .ex_rs2        (id_ex_rs2),
    .ex_rd         (id_ex_rd),
    .ex_mem_read   (id_ex_valid && id_ex_mem_read),
    .mem_rd        (ex_mem_rd),
    .mem_reg_write (ex_mem_valid && ex_mem_reg_write),
    .wb_rd         (mem_wb_rd),
    .wb_reg_write  (mem_wb_valid && mem_wb_reg_write),
    .stall         (hz_stall),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b)
  );

  assign stall = hz_stall && if_id_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex_valid     <= 1'b0;
      id_ex_reg_write <= 1'b0;
      id_ex_mem_write <= 1'b0;
    end else begin
      id_ex_valid       <= if_id_valid && !redirect && !stall;  // bubble on squash or stall
      id_ex_alu_op      <= dec_alu_op;
      id_ex_alu_src_imm <= dec_alu_src_imm;
      id_ex_reg_write   <= dec_reg_write;
      id_ex_mem_read    <= dec_mem_read;
      id_ex_mem_write   <= dec_mem_write;
      id_ex_is_branch   <= dec_is_branch;
      id_ex_is_jal      <= dec_is_jal;
      id_ex_is_ecall    <= dec_is_ecall;
      id_ex_pc          <= if_id_pc;
      id_ex_imm         <= dec_imm;
      id_ex_rs1_data    <= rs1_data;
      id_ex_rs2_data    <= rs2_data;
      id_ex_rs1         <= if_id_inst.r_view.rs1;
      id_ex_rs2         <= if_id_inst.r_view.rs2;
      id_ex_rd          <= if_id_inst.r_view.rd;
    end
  end

  assign op_a     = fwd_pick(fwd_a, id_ex_rs1_data, ex_mem_result, wb_data);
  assign op_b_reg = fwd_pick(fwd_b, id_ex_rs2_data, ex_mem_result, wb_data);
  assign alu_in_b = id_ex_alu_src_imm ? id_ex_imm : op_b_reg;

  alu u_alu (
    .alu_op       (id_ex_alu_op),
    .in_a         (op_a),
    .in_b         (alu_in_b),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  assign ex_result = id_ex_is_jal ? id_ex_pc + 32'd4 : alu_result;  // jal links pc+4

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_valid     <= 1'b0;
      ex_mem_reg_write <= 1'b0;
      ex_mem_mem_write <= 1'b0;
    end else begin
      ex_mem_valid      <= id_ex_valid;
      ex_mem_reg_write  <= id_ex_reg_write;
      ex_mem_mem_read   <= id_ex_mem_read;
      ex_mem_mem_write  <= id_ex_mem_write;
      ex_mem_is_ecall   <= id_ex_is_ecall;
      ex_mem_result     <= ex_result;
      ex_mem_store_data <= op_b_reg;
      ex_mem_rd         <= id_ex_rd;
    end
  end

  assign dmem_addr  = rv_pkg::word_t'(ex_mem_result[DMEM_AW-1:0]);
  assign dmem_wdata = ex_mem_store_data;
  assign dmem_we    = ex_mem_valid && ex_mem_mem_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb_valid     <= 1'b0;
      mem_wb_reg_write <= 1'b0;
    end else begin
      mem_wb_valid     <= ex_mem_valid;
      mem_wb_reg_write <= ex_mem_reg_write;
      mem_wb_mem_read  <= ex_mem_mem_read;
      mem_wb_is_ecall  <= ex_mem_is_ecall;
      mem_wb_result    <= ex_mem_result;
      mem_wb_rdata     <= dmem_rdata;
      mem_wb_rd        <= ex_mem_rd;
    end
  end

  assign wb_data = mem_wb_mem_read ? mem_wb_rdata : mem_wb_result;

  assign retire_valid = mem_wb_valid && mem_wb_reg_write && (mem_wb_rd != '0);
  assign retire_rd    = mem_wb_rd;
  assign retire_data  = wb_data;

  // sticky until the next reset
  always_ff @(posedge clk) begin
    if (reset) begin
      is_halted <= 1'b0;
    end else if (mem_wb_valid && mem_wb_is_ecall) begin
      is_halted <= 1'b1;
    end
  end

endmodule

/* rtl/inst_memory.sv */
`timescale 1ns/1ps

module inst_memory #(
  parameter int WORDS = 256
) (
  input  logic          clk,
  input  logic          we,
  input  rv_pkg::word_t waddr,  // word index
  input  rv_pkg::word_t wdata,
  input  rv_pkg::word_t raddr,  // byte address
  output rv_pkg::word_t rdata
);

  localparam int AW = $clog2(WORDS);

  rv_pkg::word_t mem [WORDS];

  always_ff @(posedge clk) begin
    if (we) mem[waddr[AW-1:0]] <= wdata;
  end

  assign rdata = mem[raddr[AW+1:2]];

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
  parameter int WORDS = 256
) (
  input  logic          clk,
  input  logic          we,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t wdata,
  output rv_pkg::word_t rdata
);

  localparam int AW = $clog2(WORDS);

  rv_pkg::word_t mem [WORDS];
  logic [AW-1:0] idx;

  assign idx = addr[AW+1:2];  // word aligned only

  always_ff @(posedge clk) begin
    if (we) mem[idx] <= wdata;
  end

  assign rdata = mem[idx];

endmodule

/* rtl/rv_pipe_top.sv */
`timescale 1ns/1ps

module rv_pipe_top #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             prog_we,
  input  rv_pkg::word_t    prog_addr,
  input  rv_pkg::word_t    prog_data,
  output logic             retire_valid,
  output rv_pkg::reg_idx_t retire_rd,
  output rv_pkg::word_t    retire_data,
  output logic             is_halted
);

  rv_pkg::word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  logic          dmem_we;

  cpu_core #(
    .IMEM_WORDS (IMEM_WORDS),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_core (
    .clk          (clk),
    .reset        (reset),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .dmem_we      (dmem_we),
    .dmem_rdata   (dmem_rdata),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .is_halted    (is_halted)
  );

  // program load only while the core is held in reset
  inst_memory #(.WORDS(IMEM_WORDS)) u_imem (
    .clk   (clk),
    .we    (prog_we && reset),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (imem_addr),
    .rdata (imem_data)
  );

  data_memory #(.WORDS(DMEM_WORDS)) u_dmem (
    .clk   (clk),
    .we    (dmem_we),
    .addr  (dmem_addr),
    .wdata (dmem_wdata),
    .rdata (dmem_rdata)
  );

endmodule

/* verif/rv_pipe_assert.sv */
`timescale 1ns/1ps

module rv_pipe_assert (
  input logic             clk,
  input logic             reset,
  input logic             retire_valid,
  input rv_pkg::reg_idx_t retire_rd,
  input logic             is_halted
);

  int assert_errors = 0;  // read by the testbench at the end

  // x0 writes never show up as retires
  a_retire_rd: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> retire_rd != '0)
    else begin
      $error("retire strobe with rd x0");
      assert_errors++;
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> is_halted)
    else begin
      $error("is_halted dropped without reset");
      assert_errors++;
    end

  // nothing retires once the core has halted
  a_no_retire: assert property (@(posedge clk) disable iff (reset)
    is_halted |-> !retire_valid)
    else begin
      $error("retire strobe after halt");
      assert_errors++;
    end

endmodule

bind rv_pipe_top rv_pipe_assert u_assert (
  .clk          (clk),
  .reset        (reset),
  .retire_valid (retire_valid),
  .retire_rd    (retire_rd),
  .is_halted    (is_halted)
);

/* verif/rv_pipe_tb.sv */
`timescale 1ns/1ps

module rv_pipe_tb;

  localparam int CLK_PERIOD = 8;
  localparam int TESTS      = 5;
  localparam int TEST_CYCLES = 300;  // generous per-test budget

  logic             clk;
  logic             reset;
  logic             prog_we;
  rv_pkg::word_t    prog_addr;
  rv_pkg::word_t    prog_data;
  logic             retire_valid;
  rv_pkg::reg_idx_t retire_rd;
  rv_pkg::word_t    retire_data;
  logic             is_halted;

  int error_count;
  int check_count;

  rv_pkg::word_t    prog [$];
  rv_pkg::reg_idx_t exp_rd [$];
  rv_pkg::word_t    exp_data [$];
  rv_pkg::reg_idx_t got_rd [$];
  rv_pkg::word_t    got_data [$];
  rv_pkg::word_t    xr [32];  // architectural register model
  rv_pkg::word_t    dmem_model [rv_pkg::word_t];

  rv_pipe_top #(
    .IMEM_WORDS (256),
    .DMEM_WORDS (256)
  ) uut (
    .clk          (clk),
    .reset        (reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .is_halted    (is_halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // retire strobe is stable around the falling edge
  always @(negedge clk) begin
    if (retire_valid) begin
      got_rd.push_back(retire_rd);
      got_data.push_back(retire_data);
    end
  end

  function automatic rv_pkg::word_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_R};
  endfunction

  function automatic rv_pkg::word_t encode_i(input logic [6:0] op, input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rd, rs1, input int imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t encode_s(input rv_pkg::reg_idx_t rs2, rs1, input int imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t encode_b(input logic [2:0] f3,
                                             input rv_pkg::reg_idx_t rs1, rs2, input int off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t encode_j(input rv_pkg::reg_idx_t rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  task automatic new_program();
    prog.delete();
    exp_rd.delete();
    exp_data.delete();
    dmem_model.delete();
    for (int i = 0; i < 32; i++) begin
      xr[i] = '0;
    end
  endtask

  // x0 writes are dropped and never retire
  task automatic expect_write(input int rd, input rv_pkg::word_t value);
    if (rd != 0) begin
      xr[rd] = value;
      exp_rd.push_back(5'(rd));
      exp_data.push_back(value);
    end
  endtask

  task automatic addi_insn(input int rd, input int rs1, input int imm);
    expect_write(rd, xr[rs1] + rv_pkg::word_t'(imm));
    prog.push_back(encode_i(rv_pkg::OP_IMM, 3'b000, 5'(rd), 5'(rs1), imm));
  endtask

  task automatic rr_insn(input logic [6:0] f7, input logic [2:0] f3,
                         input int rd, input int rs1, input int rs2);
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t r;
    a = xr[rs1];
    b = xr[rs2];
    case (f3)
      3'b000:  r = f7[5] ? a - b : a + b;
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b110:  r = a | b;
      default: r = a & b;
    endcase
    expect_write(rd, r);
    prog.push_back(encode_r(f7, f3, 5'(rd), 5'(rs1), 5'(rs2)));
  endtask

  task automatic load_insn(input int rd, input int rs1, input int imm);
    rv_pkg::word_t addr;
    addr = xr[rs1] + rv_pkg::word_t'(imm);
    expect_write(rd, dmem_model[addr]);
    prog.push_back(encode_i(rv_pkg::OP_LOAD, 3'b010, 5'(rd), 5'(rs1), imm));
  endtask

  task automatic store_insn(input int rs2, input int rs1, input int imm);
    rv_pkg::word_t addr;
    addr = xr[rs1] + rv_pkg::word_t'(imm);
    dmem_model[addr] = xr[rs2];
    prog.push_back(encode_s(5'(rs2), 5'(rs1), imm));
  endtask

  task automatic branch_insn(input logic [2:0] f3, input int rs1, input int rs2, input int off);
    prog.push_back(encode_b(f3, 5'(rs1), 5'(rs2), off));
  endtask

  task automatic jal_insn(input int rd, input int off);
    expect_write(rd, rv_pkg::word_t'(prog.size() * 4 + 4));  // link is pc+4
    prog.push_back(encode_j(5'(rd), off));
  endtask

  // on a path that is skipped, so no expected write
  task automatic dead_addi(input int rd, input int rs1, input int imm);
    prog.push_back(encode_i(rv_pkg::OP_IMM, 3'b000, 5'(rd), 5'(rs1), imm));
  endtask

  task automatic halt_insn();
    prog.push_back(encode_i(rv_pkg::OP_SYSTEM, 3'b000, 5'd0, 5'd0, 0));
  endtask

  task automatic compare_rd(input string name, input rv_pkg::reg_idx_t expected,
                            input rv_pkg::reg_idx_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s: rd expected x%0d, actual x%0d", name, expected, actual);
    end
  endtask

  task automatic compare_word(input string name, input rv_pkg::word_t expected,
                              input rv_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s: data expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("ERROR %s: flag expected %b, actual %b", name, expected, actual);
    end
  endtask

  // load under reset, release, wait for halt, then check the retire list
  task automatic run_program(input string name);
    @(negedge clk);
    reset = 1'b1;
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = i;
      prog_data = prog[i];
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (2) @(negedge clk);
    compare_flag(name, 1'b0, is_halted);
    compare_flag(name, 1'b0, retire_valid);
    got_rd.delete();
    got_data.delete();
    reset = 1'b0;
    while (!is_halted) @(negedge clk);
    repeat (4) @(negedge clk);  // late retires would show up here
    compare_flag(name, 1'b1, is_halted);
    if (got_rd.size() != exp_rd.size()) begin
      error_count++;
      $display("%s: %0d register writes retired but %0d were expected",
               name, got_rd.size(), exp_rd.size());
    end
    for (int i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
      compare_rd(name, exp_rd[i], got_rd[i]);
      compare_word(name, exp_data[i], got_data[i]);
    end
  endtask

  task automatic test_alu_chain();
    new_program();
    addi_insn(1, 0, 7);
    addi_insn(2, 1, -12);             // forward from memory stage
    rr_insn(7'h00, 3'b000, 3, 1, 2);  // add
    rr_insn(7'h20, 3'b000, 4, 3, 1);  // sub, result negative
    rr_insn(7'h00, 3'b111, 5, 4, 2);  // and
    rr_insn(7'h00, 3'b110, 6, 5, 3);  // or
    rr_insn(7'h00, 3'b010, 7, 4, 3);  // slt with negative rs1
    rr_insn(7'h00, 3'b010, 8, 3, 4);
    rr_insn(7'h00, 3'b000, 9, 7, 1);  // rs1 from writeback, rs2 from regfile
    addi_insn(9, 9, 1);
    rr_insn(7'h00, 3'b000, 10, 9, 9);  // newer x9 in memory stage beats writeback
    halt_insn();
    run_program("alu_chain");
  endtask

  task automatic test_store_load();
    new_program();
    addi_insn(1, 0, 64);
    addi_insn(2, 0, 1234);
    store_insn(2, 1, 8);
    load_insn(3, 1, 8);
    rr_insn(7'h00, 3'b000, 4, 3, 2);  // load-use stall
    rr_insn(7'h20, 3'b000, 5, 4, 3);
    halt_insn();
    run_program("store_load");
  endtask

  task automatic test_branches();
    new_program();
    addi_insn(1, 0, 5);
    addi_insn(2, 0, 5);
    branch_insn(3'b000, 1, 2, 12);  // beq taken
    dead_addi(3, 0, 1);
    dead_addi(4, 0, 2);
    addi_insn(5, 0, 3);
    branch_insn(3'b001, 1, 2, 8);   // bne falls through
    addi_insn(6, 0, 4);
    addi_insn(7, 5, 6);
    halt_insn();
    run_program("branches");
  endtask

  task automatic test_jump();
    new_program();
    addi_insn(1, 0, 1);
    jal_insn(2, 12);
    dead_addi(3, 0, 9);
    dead_addi(4, 0, 9);
    rr_insn(7'h00, 3'b000, 5, 2, 1);  // uses the link value
    halt_insn();
    run_program("jump");
  endtask

  task automatic test_halt_reset();
    new_program();
    addi_insn(1, 0, 3);
    addi_insn(0, 1, 5);  // x0 target
    halt_insn();
    dead_addi(2, 0, 1);
    dead_addi(3, 0, 2);
    run_program("halt_first");
    new_program();
    addi_insn(1, 0, 10);
    addi_insn(2, 1, 20);
    rr_insn(7'h00, 3'b000, 3, 2, 1);
    halt_insn();
    run_program("halt_rerun");
  endtask

  initial begin : watchdog
    #(TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d ns, %0d errors so far",
             TESTS * TEST_CYCLES * CLK_PERIOD, error_count);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    error_count = 0;
    check_count = 0;
    test_alu_chain();
    test_store_load();
    test_branches();
    test_jump();
    test_halt_reset();
    error_count += uut.u_assert.assert_errors;
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* rv_pipe.f */
common/rv_pkg.sv
core/reg_file.sv
core/decode_unit.sv
core/hazard_unit.sv
core/alu.sv
core/cpu_core.sv
rtl/inst_memory.sv
rtl/data_memory.sv
rtl/rv_pipe_top.sv
verif/rv_pipe_assert.sv
verif/rv_pipe_tb.sv

/* Makefile */
TOP := rv_pipe_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f rv_pipe.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
